// ==== verilog.f ====
memBusPkg.sv
fetchPkg.sv
tileStore.sv
fetchLookup.sv
opLength.sv
tileRefill.sv
icacheTop.sv
tbMemory.sv
icacheTb.sv

// ==== icacheTb.sv ====
`timescale 1ns/100ps

module icacheTb;
	import memBusPkg::*;
	import fetchPkg::*;

	localparam int cycleLimit = 3000;	// worst case of all tests is near 750 cycles
	localparam int holdLimit = 20;

	logic clock;
	logic reset;
	logic [memAddrWidth-1:0] pcIn;
	logic pcHold;
	logic [63:0] pcVal;
	logic [stepWidth-1:0] pcStep;
	logic [memOkWidth-1:0] pcOk;
	logic [memDataWidth-1:0] memData;
	logic [memOkWidth-1:0] memOk;
	logic [memAddrWidth-1:0] memAddr;
	logic [memOpmWidth-1:0] memOpm;
	logic [31:0] faultLow;
	logic [31:0] faultHigh;
	logic [15:0] longLow;	// word indices whose words carry the long prefix
	logic [15:0] longHigh;
	int cycleCount;
	logic [memAddrWidth-1:0] requestAddrs [$];	// every accepted tile request in order

	icacheTop icacheTop_inst (
		.clock(clock), .reset(reset), .pcIn(pcIn), .pcHold(pcHold),
		.pcVal(pcVal), .pcStep(pcStep), .pcOk(pcOk),
		.memData(memData), .memOk(memOk), .memAddr(memAddr), .memOpm(memOpm)
	);

	tbMemory tbMemory_inst (
		.clock(clock), .reset(reset), .memAddr(memAddr), .memOpm(memOpm),
		.memData(memData), .memOk(memOk), .faultLow(faultLow), .faultHigh(faultHigh),
		.longLow(longLow), .longHigh(longHigh)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#50 clock = ~clock;
	end

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
			$display("sim failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	function automatic logic [15:0] expectedWord(input logic [31:0] byteAddr);
		logic [15:0] w;
		logic [15:0] word;
		w = byteAddr[16:1];
		word[12:0] = w[12:0] ^ {w[15:13], w[15:13], w[15:13], w[15:13], w[15]};
		word[15:13] = (w >= longLow && w <= longHigh) ? longOpPrefix : {1'b0, w[1:0]};
		return word;
	endfunction

	function automatic logic [63:0] expectedWindow(input logic [31:0] pc);
		return {expectedWord(pc + 6), expectedWord(pc + 4), expectedWord(pc + 2),
			expectedWord(pc)};
	endfunction

	// cycle limit, and every accepted tile request is recorded and must be aligned
	always @(negedge clock)
	begin
		cycleCount++;
		if (cycleCount > cycleLimit)
		begin
			$display("timeout: run went past %0d cycles", cycleLimit);
			$display("sim failed");
			$fatal(1, "timeout");
		end
		else if (!reset && memOpm == memOpmRdTile && memOk == memOkReady)
		begin
			requestAddrs.push_back(memAddr);
			checkValue("memAddr[3:0]", 64'h0, memAddr[3:0]);
		end
	end

	// present pc once, then hold it until the lookup resolves
	task automatic fetch(input logic [31:0] pc, output logic [memOkWidth-1:0] status,
		output int holdCycles);
		holdCycles = 0;
		@(posedge clock);
		pcIn <= pc;
		pcHold <= 1'b0;
		@(posedge clock);
		pcHold <= 1'b1;
		@(negedge clock);
		while (pcOk == memOkHold)
		begin
			holdCycles++;
			if (holdCycles >= holdLimit)
			begin
				$display("fetch of pc %h still waiting after %0d cycles", pc, holdLimit);
				$display("sim failed");
				$fatal(1, "fetch stuck in Hold");
			end
			else
				@(negedge clock);
		end
		status = pcOk;
	endtask

	task automatic checkWindow(input logic [31:0] pc, input logic [memOkWidth-1:0] status);
		logic [15:0] first;
		first = expectedWord(pc);
		checkValue("pcOk", memOkOk, status);
		checkValue("pcVal", expectedWindow(pc), pcVal);
		checkValue("pcStep", (first[15:13] == longOpPrefix) ? stepLong : stepShort, pcStep);
	endtask

	task automatic coldMissThenHit();
		logic [memOkWidth-1:0] status;
		int holdCycles;
		fetch(32'h0000_0100, status, holdCycles);
		checkValue("cold miss saw Hold", 1, holdCycles > 0);
		checkWindow(32'h0000_0100, status);
		fetch(32'h0000_0100, status, holdCycles);
		checkValue("hit Hold cycles", 0, holdCycles);
		checkValue("memOpm", memOpmReady, memOpm);
		checkWindow(32'h0000_0100, status);
	endtask

	task automatic crossingWindows();
		logic [memOkWidth-1:0] status;
		int holdCycles;
		int startCount;
		int k;
		startCount = requestAddrs.size();
		for (k = 0; k < 4; k++)
		begin
			fetch(32'h0000_0208 + 2*k, status, holdCycles);
			checkWindow(32'h0000_0208 + 2*k, status);
			if (k == 0)
			begin
				// next tile feeds the even half and goes first
				checkValue("tile requests", 2, requestAddrs.size() - startCount);
				checkValue("memAddr even tile", 32'h0000_0210, requestAddrs[startCount]);
				checkValue("memAddr odd tile", 32'h0000_0200, requestAddrs[startCount + 1]);
			end
			else
				checkValue("crossing hit Hold cycles", 0, holdCycles);
		end
	endtask

	// tile 0x800 is all long words, its neighbours all short
	task automatic stepDecode();
		logic [memOkWidth-1:0] status;
		int holdCycles;
		int i;
		for (i = 0; i < 20; i++)
		begin
			fetch(32'h0000_07f8 + 2*i, status, holdCycles);
			checkWindow(32'h0000_07f8 + 2*i, status);
		end
	endtask

	task automatic holdKeepsWindow();
		logic [memOkWidth-1:0] status;
		int holdCycles;
		fetch(32'h0000_0100, status, holdCycles);
		checkWindow(32'h0000_0100, status);
		@(posedge clock);
		pcIn <= 32'h0000_0208;	// ignored while held
		repeat (3)
		begin
			@(negedge clock);
			checkValue("pcVal under hold", expectedWindow(32'h0000_0100), pcVal);
		end
	endtask

	// 0x1000 and 0x1400 both map to set 0
	task automatic setConflict();
		logic [memOkWidth-1:0] status;
		int holdCycles;
		int round;
		for (round = 0; round < 2; round++)
		begin
			fetch(32'h0000_1000, status, holdCycles);
			checkValue("first tile evicted", 1, holdCycles > 0);
			checkWindow(32'h0000_1000, status);
			fetch(32'h0000_1400, status, holdCycles);
			checkValue("second tile evicted", 1, holdCycles > 0);
			checkWindow(32'h0000_1400, status);
		end
	endtask

	task automatic faultRecovery();
		logic [memOkWidth-1:0] status;
		int holdCycles;
		fetch(32'h0000_3004, status, holdCycles);
		checkValue("pcOk on fault", memOkFault, status);
		fetch(32'h0000_0300, status, holdCycles);
		checkWindow(32'h0000_0300, status);
	endtask

	initial
	begin
		void'($urandom(32'h32e00dca));
		reset = 1'b1;
		pcIn = '0;
		pcHold = 1'b0;
		faultLow = 32'h0000_3000;
		faultHigh = 32'h0000_30f0;
		longLow = 16'h0400;
		longHigh = 16'h0407;
		cycleCount = 0;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		coldMissThenHit();
		crossingWindows();
		stepDecode();
		holdKeepsWindow();
		setConflict();
		faultRecovery();
		$display("sim passed");
		$finish;
	end

endmodule

// ==== tbMemory.sv ====
`timescale 1ns/100ps

module tbMemory (
	input logic clock,
	input logic reset,
	input logic [memBusPkg::memAddrWidth-1:0] memAddr,
	input logic [memBusPkg::memOpmWidth-1:0] memOpm,
	output logic [memBusPkg::memDataWidth-1:0] memData,
	output logic [memBusPkg::memOkWidth-1:0] memOk,
	input logic [31:0] faultLow,
	input logic [31:0] faultHigh,
	input logic [15:0] longLow,
	input logic [15:0] longHigh
);
	import memBusPkg::*;

	logic [2:0] holdLeft;	// extra Hold cycles after the first
	logic [memAddrWidth-1:0] tileAddr;

	// content depends only on the word index a[16:1]
	function automatic logic [15:0] wordAt(input logic [31:0] byteAddr);
		logic [15:0] w;
		logic [15:0] word;
		w = byteAddr[16:1];
		word[12:0] = w[12:0] ^ {w[15:13], w[15:13], w[15:13], w[15:13], w[15]};
		word[15:13] = (w >= longLow && w <= longHigh) ? 3'b111 : {1'b0, w[1:0]};
		return word;
	endfunction

	function automatic logic [memDataWidth-1:0] tileAt(input logic [31:0] base);
		logic [memDataWidth-1:0] data;
		int i;
		for (i = 0; i < 8; i++)
			data[16*i +: 16] = wordAt(base + 2*i);
		return data;
	endfunction

	always @(posedge clock)
	begin
		if (reset)
		begin
			memOk <= memOkReady;
			memData <= '0;
			holdLeft <= '0;
			tileAddr <= '0;
		end
		else
		begin
			case (memOk)
				memOkReady:
				begin
					if (memOpm == memOpmRdTile)
					begin
						tileAddr <= {memAddr[memAddrWidth-1:4], 4'b0000};
						holdLeft <= 3'($urandom_range(3, 0));	// 1 to 4 Hold cycles
						memOk <= memOkHold;
					end
				end
				memOkHold:
				begin
					if (holdLeft != 0)
						holdLeft <= holdLeft - 1'b1;
					else if (tileAddr >= faultLow && tileAddr <= faultHigh)
					begin
						memOk <= memOkFault;
						memData <= '0;
					end
					else
					begin
						memOk <= memOkOk;
						memData <= tileAt(tileAddr);
					end
				end
				default:
				begin
					memOk <= memOkReady;	// cache already shows Ready here
				end
			endcase
		end
	end

endmodule

// ==== icacheTop.sv ====
`timescale 1ns/100ps

module icacheTop (
	input logic clock,
	input logic reset,
	input logic [memBusPkg::memAddrWidth-1:0] pcIn,
	input logic pcHold,
	output logic [63:0] pcVal,
	output logic [fetchPkg::stepWidth-1:0] pcStep,
	output logic [memBusPkg::memOkWidth-1:0] pcOk,
	input logic [memBusPkg::memDataWidth-1:0] memData,
	input logic [memBusPkg::memOkWidth-1:0] memOk,
	output logic [memBusPkg::memAddrWidth-1:0] memAddr,
	output logic [memBusPkg::memOpmWidth-1:0] memOpm
);
	import memBusPkg::*;
	import fetchPkg::*;

	logic [memAddrWidth-1:0] reqPc;
	halfData evenHalf;
	halfData oddHalf;
	logic [tileAddrWidth-1:0] reqTileEven;
	logic [tileAddrWidth-1:0] reqTileOdd;
	logic missEven;
	logic missOdd;
	logic fillValid;	// refill to lookup arrays
	logic [tileAddrWidth-1:0] fillTile;
	logic [memDataWidth-1:0] fillData;
	logic refillFault;

	fetchLookup fetchLookup_inst (
		.clock(clock),
		.reset(reset),
		.pcIn(pcIn),
		.pcHold(pcHold),
		.fillValid(fillValid),
		.fillTile(fillTile),
		.fillData(fillData),
		.refillFault(refillFault),
		.reqPc(reqPc),
		.evenHalf(evenHalf),
		.oddHalf(oddHalf),
		.reqTileEven(reqTileEven),
		.reqTileOdd(reqTileOdd),
		.missEven(missEven),
		.missOdd(missOdd),
		.pcOk(pcOk)
	);

	opLength opLength_inst (
		.reqPc(reqPc),
		.evenHalf(evenHalf),
		.oddHalf(oddHalf),
		.pcVal(pcVal),
		.pcStep(pcStep)
	);

	tileRefill tileRefill_inst (
		.clock(clock),
		.reset(reset),
		.missEven(missEven),
		.missOdd(missOdd),
		.reqTileEven(reqTileEven),
		.reqTileOdd(reqTileOdd),
		.memData(memData),
		.memOk(memOk),
		.memAddr(memAddr),
		.memOpm(memOpm),
		.fillValid(fillValid),
		.fillTile(fillTile),
		.fillData(fillData),
		.refillFault(refillFault)
	);

endmodule

// ==== tileRefill.sv ====
`timescale 1ns/100ps

module tileRefill (
	input logic clock,
	input logic reset,
	input logic missEven,
	input logic missOdd,
	input logic [fetchPkg::tileAddrWidth-1:0] reqTileEven,
	input logic [fetchPkg::tileAddrWidth-1:0] reqTileOdd,
	input logic [memBusPkg::memDataWidth-1:0] memData,
	input logic [memBusPkg::memOkWidth-1:0] memOk,
	output logic [memBusPkg::memAddrWidth-1:0] memAddr,
	output logic [memBusPkg::memOpmWidth-1:0] memOpm,
	output logic fillValid,
	output logic [fetchPkg::tileAddrWidth-1:0] fillTile,
	output logic [memBusPkg::memDataWidth-1:0] fillData,
	output logic refillFault
);
	import memBusPkg::*;
	import fetchPkg::*;

	typedef enum logic [1:0] {
		idle,
		request,	// first cycle of RdTile
		drain,	// waiting out Hold
		waitReady	// Ready driven until the memory goes idle
	} refillState;

	refillState state;
	logic [tileAddrWidth-1:0] targetTile;
	logic responded;

	assign responded = (state == drain) && (memOk == memOkOk || memOk == memOkFault);

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= idle;
		else
		begin
			case (state)
				idle:
				begin
					if ((missEven || missOdd) && memOk == memOkReady)
						state <= request;
				end
				request:
				begin
					state <= drain;
				end
				drain:
				begin
					if (responded)
						state <= waitReady;
				end
				default:
				begin
					if (memOk == memOkReady)
						state <= idle;
				end
			endcase
		end
	end

	// frozen once the request leaves idle, even half has priority
	always_ff @(posedge clock)
	begin
		if (state == idle)
			targetTile <= missEven ? reqTileEven : reqTileOdd;
	end

	assign memAddr = {targetTile, {(memAddrWidth - tileAddrWidth){1'b0}}};	// tile aligned

	// dropped to Ready in the response cycle itself
	assign memOpm = (state == request || (state == drain && !responded)) ?
		memOpmRdTile : memOpmReady;

	assign fillValid = (state == drain) && (memOk == memOkOk);
	assign refillFault = (state == drain) && (memOk == memOkFault);
	assign fillTile = targetTile;
	assign fillData = memData;

	// a new read starts only on an idle bus, never over a pending response
	requestOnIdleBus: assert property (
		@(posedge clock) disable iff (reset)
		(state == request) |-> (memOk == memOkReady)
	)
	else
		$error("tileRefill: RdTile raised while the memory was not Ready");

	// memory must give Ok for exactly one cycle
	fillSingleCycle: assert property (
		@(posedge clock) disable iff (reset) fillValid |=> (memOk != memOkOk)
	)
	else
		$error("tileRefill: memory held Ok longer than one cycle");

endmodule

// ==== opLength.sv ====
`timescale 1ns/100ps

module opLength (
	input logic [memBusPkg::memAddrWidth-1:0] reqPc,
	input fetchPkg::halfData evenHalf,
	input fetchPkg::halfData oddHalf,
	output logic [63:0] pcVal,
	output logic [fetchPkg::stepWidth-1:0] pcStep
);
	import fetchPkg::*;

	logic [2*halfWidth-1:0] window;
	logic [15:0] firstWord;

	// bit 3 set means the odd half belongs to the lower tile
	always_comb
	begin
		if (reqPc[3])
			window = {evenHalf, oddHalf};
		else
			window = {oddHalf, evenHalf};
	end

	// four 16-bit words starting at the word index
	always_comb
	begin
		case (reqPc[2:1])
			2'd0:
			begin
				pcVal = window[63:0];
			end
			2'd1:
			begin
				pcVal = window[79:16];
			end
			2'd2:
			begin
				pcVal = window[95:32];
			end
			default:
			begin
				pcVal = window[111:48];
			end
		endcase
	end

	assign firstWord = pcVal[15:0];

	// only 16 and 32 bit ops, the prefix marks the long form
	always_comb
	begin
		if (firstWord[15:13] == longOpPrefix)
			pcStep = stepLong;
		else
			pcStep = stepShort;
	end

endmodule

// ==== fetchLookup.sv ====
`timescale 1ns/100ps

module fetchLookup (
	input logic clock,
	input logic reset,
	input logic [memBusPkg::memAddrWidth-1:0] pcIn,
	input logic pcHold,
	input logic fillValid,
	input logic [fetchPkg::tileAddrWidth-1:0] fillTile,
	input logic [memBusPkg::memDataWidth-1:0] fillData,
	input logic refillFault,
	output logic [memBusPkg::memAddrWidth-1:0] reqPc,
	output fetchPkg::halfData evenHalf,
	output fetchPkg::halfData oddHalf,
	output logic [fetchPkg::tileAddrWidth-1:0] reqTileEven,
	output logic [fetchPkg::tileAddrWidth-1:0] reqTileOdd,
	output logic missEven,
	output logic missOdd,
	output logic [memBusPkg::memOkWidth-1:0] pcOk
);
	import memBusPkg::*;
	import fetchPkg::*;

	logic [memAddrWidth-1:0] nextPc;
	logic [tileAddrWidth-1:0] nextTileEven;
	logic [tileAddrWidth-1:0] nextTileOdd;
	logic [setIndexWidth-1:0] nextSetEven;
	logic [setIndexWidth-1:0] nextSetOdd;
	logic [setIndexWidth-1:0] fillSet;
	logic [setCount-1:0] setValid;	// cleared by reset, no sweep of the tag arrays
	logic validEven;
	logic validOdd;
	fetchTag tagEven;
	fetchTag tagOdd;
	fetchTag fillTag;
	halfData fillEven;
	halfData fillOdd;

	assign nextPc = pcHold ? reqPc : pcIn;	// held pc is looked up again

	// with pc bit 3 set the window runs into the next tile
	always_comb
	begin
		if (nextPc[3])
		begin
			nextTileOdd = nextPc[memAddrWidth-1:4];
			nextTileEven = nextTileOdd + 1'b1;
		end
		else
		begin
			nextTileEven = nextPc[memAddrWidth-1:4];
			nextTileOdd = nextTileEven;
		end
	end

	assign nextSetEven = nextTileEven[setIndexWidth-1:0];
	assign nextSetOdd = nextTileOdd[setIndexWidth-1:0];

	// refill always writes a whole tile, both halves and both tags
	assign fillSet = fillTile[setIndexWidth-1:0];
	assign fillEven = fillData[halfWidth-1:0];
	assign fillOdd = fillData[2*halfWidth-1:halfWidth];
	assign fillTag = '{valid: 1'b1, tile: fillTile};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqPc <= '0;
			reqTileEven <= '0;
			reqTileOdd <= '0;
			validEven <= 1'b0;
			validOdd <= 1'b0;
			setValid <= '0;
		end
		else
		begin
			reqPc <= nextPc;
			reqTileEven <= nextTileEven;
			reqTileOdd <= nextTileOdd;
			validEven <= setValid[nextSetEven];	// read alongside the arrays
			validOdd <= setValid[nextSetOdd];
			if (fillValid)
				setValid[fillSet] <= 1'b1;
		end
	end

	tileStore #(.payload(halfData)) evenData_inst (
		.clock(clock),
		.readIndex(nextSetEven),
		.readData(evenHalf),
		.writeEnable(fillValid),
		.writeIndex(fillSet),
		.writeData(fillEven)
	);

	tileStore #(.payload(halfData)) oddData_inst (
		.clock(clock),
		.readIndex(nextSetOdd),
		.readData(oddHalf),
		.writeEnable(fillValid),
		.writeIndex(fillSet),
		.writeData(fillOdd)
	);

	tileStore #(.payload(fetchTag)) evenTag_inst (
		.clock(clock),
		.readIndex(nextSetEven),
		.readData(tagEven),
		.writeEnable(fillValid),
		.writeIndex(fillSet),
		.writeData(fillTag)
	);

	tileStore #(.payload(fetchTag)) oddTag_inst (
		.clock(clock),
		.readIndex(nextSetOdd),
		.readData(tagOdd),
		.writeEnable(fillValid),
		.writeIndex(fillSet),
		.writeData(fillTag)
	);

	assign missEven = !(validEven && tagEven.valid && tagEven.tile == reqTileEven);
	assign missOdd = !(validOdd && tagOdd.valid && tagOdd.tile == reqTileOdd);

	always_comb
	begin
		if (refillFault)
			pcOk = memOkFault;	// one cycle only, tile not written
		else if (missEven || missOdd)
			pcOk = memOkHold;
		else
			pcOk = memOkOk;
	end

endmodule

// ==== tileStore.sv ====
`timescale 1ns/100ps

module tileStore #(
	parameter type payload = fetchPkg::halfData
) (
	input logic clock,
	input logic [fetchPkg::setIndexWidth-1:0] readIndex,
	output payload readData,
	input logic writeEnable,
	input logic [fetchPkg::setIndexWidth-1:0] writeIndex,
	input payload writeData
);
	import fetchPkg::*;

	payload entries [setCount];	// small enough for distributed ram

	// read is registered, a write lands at the same edge
	// so a same-cycle read of that set still returns the old entry
	always_ff @(posedge clock)
	begin
		if (writeEnable)
			entries[writeIndex] <= writeData;
		readData <= entries[readIndex];
	end

	// a refill index of x would corrupt an unknown set
	writeIndexKnown: assert property (
		@(posedge clock) writeEnable |-> !$isunknown(writeIndex)
	)
	else
		$error("tileStore: write with unknown index");

endmodule

// ==== fetchPkg.sv ====
package fetchPkg;

	// direct-mapped geometry
	localparam int setCount = 64;
	localparam int setIndexWidth = 6;	// log2 of setCount
	localparam int tileAddrWidth = 28;	// pc with byte-in-tile bits dropped
	localparam int halfWidth = 64;	// even or odd half of a tile

	// tag payload, stored once per half
	typedef struct packed {
		logic valid;
		logic [tileAddrWidth-1:0] tile;
	} fetchTag;

	// data payload
	typedef logic [halfWidth-1:0] halfData;

	// instruction length decode
	localparam logic [2:0] longOpPrefix = 3'b111;	// top bits of a 32-bit op's first word
	localparam int stepWidth = 3;
	localparam logic [stepWidth-1:0] stepShort = 3'd1;	// in 16-bit words
	localparam logic [stepWidth-1:0] stepLong = 3'd2;

endpackage

// ==== memBusPkg.sv ====
package memBusPkg;

	// bus widths
	localparam int memDataWidth = 128;	// one whole tile per transfer
	localparam int memAddrWidth = 32;
	localparam int memOpmWidth = 5;
	localparam int memOkWidth = 2;

	// operation codes driven by the requester
	localparam logic [memOpmWidth-1:0] memOpmReady = 5'b00000;	// bus idle
	localparam logic [memOpmWidth-1:0] memOpmRdTile = 5'b01111;	// read one 128-bit tile

	// status codes driven by the memory, the cache reuses them for pcOk
	localparam logic [memOkWidth-1:0] memOkReady = 2'b00;	// idle, may accept a request
	localparam logic [memOkWidth-1:0] memOkOk = 2'b01;	// data valid this cycle
	localparam logic [memOkWidth-1:0] memOkHold = 2'b10;	// busy
	localparam logic [memOkWidth-1:0] memOkFault = 2'b11;	// bus error

endpackage
